// ==== src/rv_pkg.sv ====
// RV32I core package
// Shared word and field types, opcode and ALU codes, and the bundles
// passed between decode, execute and commit
`default_nettype none

package rv_pkg;

  // Plain vector types for the widths that carry a meaning
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  alu_op_t;

  // ALU operation codes
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  // Forwards operand B, used by LUI
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // Major opcodes, bits 6:0 of the instruction
  localparam opcode_t OPCODE_LOAD     = 7'b0000011;
  localparam opcode_t OPCODE_LOAD_FP  = 7'b0000111;
  localparam opcode_t OPCODE_OP_IMM   = 7'b0010011;
  localparam opcode_t OPCODE_AUIPC    = 7'b0010111;
  localparam opcode_t OPCODE_STORE    = 7'b0100011;
  localparam opcode_t OPCODE_STORE_FP = 7'b0100111;
  localparam opcode_t OPCODE_OP       = 7'b0110011;
  localparam opcode_t OPCODE_LUI      = 7'b0110111;
  localparam opcode_t OPCODE_BRANCH   = 7'b1100011;
  localparam opcode_t OPCODE_JALR     = 7'b1100111;
  localparam opcode_t OPCODE_JAL      = 7'b1101111;

  // Decoder output, consumed by execute and commit
  typedef struct packed {
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    funct3_t   funct3;
    alu_op_t   alu_op;
    word_t     imm;
    logic      operand_a_is_pc;
    logic      operand_b_is_imm;
    logic      writes_rd;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      illegal;
  } decoded_t;

  // Execute output
  typedef struct packed {
    // ALU result, or the link address for jumps
    word_t value;
    word_t target;
    // PC goes to target instead of PC plus 4
    logic  redirect;
  } exec_result_t;

  // One retired instruction as seen on the retire port
  typedef struct packed {
    word_t     pc;
    word_t     next_pc;
    reg_addr_t rd;
    word_t     data;
    logic      writes_rd;
    logic      illegal;
  } retire_t;

endpackage

`default_nettype wire

// ==== src/immediate_generator.sv ====
// Immediate generator
// Builds the sign-extended immediate of an RV32I instruction from its
// format, which follows from the major opcode
`timescale 1ns/100ps
`default_nettype none

module immediate_generator (
  input  rv_pkg::word_t inst,
  output rv_pkg::word_t immediate
);

  rv_pkg::opcode_t opcode;

  assign opcode = inst[6:0];

  // Bit layout per format
  //   I  sign[31:11] inst[30:25] inst[24:20]
  //   S  sign[31:11] inst[30:25] inst[11:7]
  //   B  sign[31:12] inst[7] inst[30:25] inst[11:8] 0
  //   U  inst[31:12] then twelve zeros
  //   J  sign[31:20] inst[19:12] inst[20] inst[30:25] inst[24:21] 0
  always_comb begin
    case (opcode)
      // I format
      rv_pkg::OPCODE_LOAD,
      rv_pkg::OPCODE_LOAD_FP,
      rv_pkg::OPCODE_OP_IMM,
      rv_pkg::OPCODE_JALR: begin
        immediate = {{21{inst[31]}}, inst[30:25], inst[24:20]};
      end
      // S format, rd field holds the low bits
      rv_pkg::OPCODE_STORE,
      rv_pkg::OPCODE_STORE_FP: begin
        immediate = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      end
      // B format, byte offset in halfword steps
      rv_pkg::OPCODE_BRANCH: begin
        immediate = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      // U format
      rv_pkg::OPCODE_LUI,
      rv_pkg::OPCODE_AUIPC: begin
        immediate = {inst[31:12], 12'd0};
      end
      // J format
      rv_pkg::OPCODE_JAL: begin
        immediate = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:25], inst[24:21], 1'b0};
      end
      default: begin
        immediate = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/instruction_decoder.sv ====
// Instruction decoder
// Splits an RV32I instruction into register fields, ALU operation,
// operand selects and control flags
`timescale 1ns/100ps
`default_nettype none

module instruction_decoder (
  input  rv_pkg::word_t     inst,
  output rv_pkg::decoded_t  decoded,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr
);

  rv_pkg::opcode_t opcode;
  rv_pkg::funct3_t funct3;
  rv_pkg::word_t   immediate;
  rv_pkg::alu_op_t arith_op;
  logic            shift_bad;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  immediate_generator i_immediate_generator (
    .inst      (inst),
    .immediate (immediate)
  );

  // ALU op shared by OP and OP_IMM
  // Bit 30 picks sub only for OP, and sra for both
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == rv_pkg::OPCODE_OP && inst[30]) ? rv_pkg::ALU_SUB
                                                                     : rv_pkg::ALU_ADD;
      3'b001:  arith_op = rv_pkg::ALU_SLL;
      3'b010:  arith_op = rv_pkg::ALU_SLT;
      3'b011:  arith_op = rv_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_pkg::ALU_XOR;
      3'b101:  arith_op = inst[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
  end

  // Immediate shifts need zero upper funct7 bits, srai may also set bit 30
  assign shift_bad = (funct3 == 3'b001 && inst[31:25] != 7'd0) ||
                     (funct3 == 3'b101 && {inst[31], inst[29:25]} != 6'd0);

  always_comb begin
    decoded        = '0;
    decoded.rd     = inst[11:7];
    decoded.rs1    = inst[19:15];
    decoded.rs2    = inst[24:20];
    decoded.funct3 = funct3;
    decoded.imm    = immediate;
    decoded.alu_op = rv_pkg::ALU_ADD;
    case (opcode)
      rv_pkg::OPCODE_OP: begin
        decoded.alu_op    = arith_op;
        decoded.writes_rd = 1'b1;
      end
      rv_pkg::OPCODE_OP_IMM: begin
        decoded.alu_op           = arith_op;
        decoded.operand_b_is_imm = 1'b1;
        // Bad shift encodings retire as illegal without a write
        decoded.illegal          = shift_bad;
        decoded.writes_rd        = !shift_bad;
      end
      rv_pkg::OPCODE_LUI: begin
        decoded.alu_op           = rv_pkg::ALU_PASS_B;
        decoded.operand_b_is_imm = 1'b1;
        decoded.writes_rd        = 1'b1;
      end
      rv_pkg::OPCODE_AUIPC: begin
        decoded.operand_a_is_pc  = 1'b1;
        decoded.operand_b_is_imm = 1'b1;
        decoded.writes_rd        = 1'b1;
      end
      rv_pkg::OPCODE_JAL: begin
        decoded.is_jal    = 1'b1;
        decoded.writes_rd = 1'b1;
      end
      rv_pkg::OPCODE_JALR: begin
        decoded.is_jalr   = 1'b1;
        decoded.writes_rd = 1'b1;
      end
      // Comparison happens outside the ALU
      rv_pkg::OPCODE_BRANCH: begin
        decoded.is_branch = 1'b1;
      end
      // Loads, stores, FP, FENCE, SYSTEM and anything unknown
      default: begin
        decoded.illegal = 1'b1;
      end
    endcase
  end

  assign rs1_addr = decoded.rs1;
  assign rs2_addr = decoded.rs2;

endmodule

`default_nettype wire

// ==== src/integer_execute.sv ====
// Integer execute stage
// ALU, branch condition and jump or branch target, all combinational
`timescale 1ns/100ps
`default_nettype none

module integer_execute (
  input  rv_pkg::word_t        pc,
  input  rv_pkg::decoded_t     decoded,
  input  rv_pkg::word_t        rs1_data,
  input  rv_pkg::word_t        rs2_data,
  output rv_pkg::exec_result_t result
);

  rv_pkg::word_t operand_a;
  rv_pkg::word_t operand_b;
  rv_pkg::word_t alu_out;
  rv_pkg::word_t pc_plus_4;
  rv_pkg::word_t jalr_sum;
  logic [4:0]    shamt;
  logic          taken;
  logic          is_jump;

  // AUIPC uses the PC, immediate forms use imm
  assign operand_a = decoded.operand_a_is_pc  ? pc          : rs1_data;
  assign operand_b = decoded.operand_b_is_imm ? decoded.imm : rs2_data;
  assign shamt     = operand_b[4:0];
  assign pc_plus_4 = pc + 32'd4;
  assign is_jump   = decoded.is_jal || decoded.is_jalr;

  always_comb begin
    case (decoded.alu_op)
      rv_pkg::ALU_ADD:    alu_out = operand_a + operand_b;
      rv_pkg::ALU_SUB:    alu_out = operand_a - operand_b;
      rv_pkg::ALU_SLL:    alu_out = operand_a << shamt;
      rv_pkg::ALU_SLT:    alu_out = {31'd0, $signed(operand_a) < $signed(operand_b)};
      rv_pkg::ALU_SLTU:   alu_out = {31'd0, operand_a < operand_b};
      rv_pkg::ALU_XOR:    alu_out = operand_a ^ operand_b;
      rv_pkg::ALU_SRL:    alu_out = operand_a >> shamt;
      rv_pkg::ALU_SRA:    alu_out = rv_pkg::word_t'($signed(operand_a) >>> shamt);
      rv_pkg::ALU_OR:     alu_out = operand_a | operand_b;
      rv_pkg::ALU_AND:    alu_out = operand_a & operand_b;
      rv_pkg::ALU_PASS_B: alu_out = operand_b;
      default:            alu_out = '0;
    endcase
  end

  // Branch condition from funct3, reserved encodings never branch
  always_comb begin
    case (decoded.funct3)
      3'b000:  taken = rs1_data == rs2_data;
      3'b001:  taken = rs1_data != rs2_data;
      3'b100:  taken = $signed(rs1_data) <  $signed(rs2_data);
      3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  taken = rs1_data <  rs2_data;
      3'b111:  taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_data + decoded.imm;

  // Jumps link PC plus 4, everything else returns the ALU value
  assign result.value    = is_jump ? pc_plus_4 : alu_out;
  // JALR drops bit 0 of its sum
  assign result.target   = decoded.is_jalr ? {jalr_sum[31:1], 1'b0} : pc + decoded.imm;
  assign result.redirect = is_jump || (decoded.is_branch && taken);

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
// Integer register file
// x1 to x31 with one synchronous write port and two asynchronous
// read ports, x0 always reads zero
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  logic              clock,
  input  logic              reset,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::word_t     rd_data,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  // No storage for x0
  rv_pkg::word_t regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Reads see the value from the last edge, so a dependent
  // instruction in the next cycle gets the new data
  always_comb begin
    if (rs1_addr == 5'd0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    if (rs2_addr == 5'd0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

`default_nettype wire

// ==== src/result_commit.sv ====
// Result commit
// Owns the PC and the register file, applies each strobed instruction
// and registers its retire record for one cycle
`timescale 1ns/100ps
`default_nettype none

module result_commit #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 inst_valid,
  input  rv_pkg::decoded_t     decoded,
  input  rv_pkg::exec_result_t exec,
  input  rv_pkg::reg_addr_t    rs1_addr,
  input  rv_pkg::reg_addr_t    rs2_addr,
  output rv_pkg::word_t        rs1_data,
  output rv_pkg::word_t        rs2_data,
  output rv_pkg::word_t        pc,
  output logic                 retire_valid,
  output rv_pkg::retire_t      retire
);

  rv_pkg::word_t next_pc;
  logic          rd_we;

  // Taken branches and jumps redirect, illegal ones fall through
  assign next_pc = exec.redirect ? exec.target : pc + 32'd4;

  // Write only for a valid legal instruction with a real destination
  assign rd_we = inst_valid && decoded.writes_rd && !decoded.illegal &&
                 decoded.rd != 5'd0;

  register_file i_register_file (
    .clock    (clock),
    .reset    (reset),
    .we       (rd_we),
    .rd_addr  (decoded.rd),
    .rd_data  (exec.value),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // PC and retire strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      pc           <= RESET_PC;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= inst_valid;
      if (inst_valid) begin
        pc <= next_pc;
      end
    end
  end

  // Retire record, only meaningful while retire_valid is high
  always_ff @(posedge clock) begin
    if (inst_valid) begin
      retire.pc        <= pc;
      retire.next_pc   <= next_pc;
      retire.rd        <= decoded.rd;
      retire.data      <= exec.value;
      retire.writes_rd <= decoded.writes_rd && !decoded.illegal;
      retire.illegal   <= decoded.illegal;
    end
  end

endmodule

`default_nettype wire

// ==== src/rv_core_top.sv ====
// RV32I core top level
// One instruction per strobe through decode, execute and commit,
// retired on a registered port one cycle later
`timescale 1ns/100ps
`default_nettype none

module rv_core_top #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            inst_valid,
  input  rv_pkg::word_t   inst,
  output logic            retire_valid,
  output rv_pkg::retire_t retire
);

  rv_pkg::decoded_t     decoded;
  rv_pkg::exec_result_t exec;
  rv_pkg::reg_addr_t    rs1_addr;
  rv_pkg::reg_addr_t    rs2_addr;
  rv_pkg::word_t        rs1_data;
  rv_pkg::word_t        rs2_data;
  rv_pkg::word_t        pc;

  instruction_decoder i_instruction_decoder (
    .inst     (inst),
    .decoded  (decoded),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr)
  );

  // Register reads come back from the commit block
  integer_execute i_integer_execute (
    .pc       (pc),
    .decoded  (decoded),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (exec)
  );

  result_commit #(
    .RESET_PC (RESET_PC)
  ) i_result_commit (
    .clock        (clock),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .decoded      (decoded),
    .exec         (exec),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

`default_nettype wire

// ==== bench/rv_ref_model.svh ====
// RV32I reference model for the core testbench
// Keeps its own register array and PC, and steps one instruction at a
// time into the retire record the core should produce
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Architectural state of the model
rv_pkg::word_t model_regs [0:31];
rv_pkg::word_t model_pc;

function automatic void reset_model(input rv_pkg::word_t start_pc);
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  model_pc = start_pc;
endfunction

// Immediate by format, straight from the encoding tables
function automatic rv_pkg::word_t expected_immediate(input rv_pkg::word_t inst);
  case (inst[6:0])
    rv_pkg::OPCODE_OP_IMM,
    rv_pkg::OPCODE_JALR:   return {{20{inst[31]}}, inst[31:20]};
    rv_pkg::OPCODE_BRANCH: return {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                   inst[11:8], 1'b0};
    rv_pkg::OPCODE_LUI,
    rv_pkg::OPCODE_AUIPC:  return {inst[31:12], 12'h000};
    rv_pkg::OPCODE_JAL:    return {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                   inst[30:21], 1'b0};
    default:               return '0;
  endcase
endfunction

// Integer operation by funct3, alt selects sub or sra
function automatic rv_pkg::word_t alu_result(input logic [2:0] f3, input logic alt,
                                             input rv_pkg::word_t a, input rv_pkg::word_t b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

// One instruction: expected retire record, then update the model state
function automatic rv_pkg::retire_t step_model(input rv_pkg::word_t inst);
  rv_pkg::retire_t r;
  rv_pkg::word_t   imm;
  rv_pkg::word_t   a;
  rv_pkg::word_t   b;
  rv_pkg::word_t   value;
  rv_pkg::word_t   next;
  logic [2:0]      f3;
  logic            write;
  logic            bad;
  logic            taken;
  imm   = expected_immediate(inst);
  a     = model_regs[inst[19:15]];
  b     = model_regs[inst[24:20]];
  f3    = inst[14:12];
  value = '0;
  write = 1'b0;
  bad   = 1'b0;
  next  = model_pc + 32'd4;
  case (inst[6:0])
    rv_pkg::OPCODE_OP: begin
      value = alu_result(f3, inst[30], a, b);
      write = 1'b1;
    end
    rv_pkg::OPCODE_OP_IMM: begin
      // slli needs funct7 zero, srli or srai allow only bit 30
      if (f3 == 3'd1) begin
        bad = inst[31:25] != 7'h00;
      end else if (f3 == 3'd5) begin
        bad = inst[31:25] != 7'h00 && inst[31:25] != 7'h20;
      end
      value = alu_result(f3, f3 == 3'd5 && inst[30], a, imm);
      write = !bad;
    end
    rv_pkg::OPCODE_LUI: begin
      value = imm;
      write = 1'b1;
    end
    rv_pkg::OPCODE_AUIPC: begin
      value = model_pc + imm;
      write = 1'b1;
    end
    rv_pkg::OPCODE_JAL: begin
      value = model_pc + 32'd4;
      next  = model_pc + imm;
      write = 1'b1;
    end
    rv_pkg::OPCODE_JALR: begin
      value = model_pc + 32'd4;
      next  = (a + imm) & ~32'd1;
      write = 1'b1;
    end
    rv_pkg::OPCODE_BRANCH: begin
      case (f3)
        3'd0:    taken = a == b;
        3'd1:    taken = a != b;
        3'd4:    taken = $signed(a) < $signed(b);
        3'd5:    taken = $signed(a) >= $signed(b);
        3'd6:    taken = a < b;
        default: taken = a >= b;
      endcase
      if (taken) begin
        next = model_pc + imm;
      end
    end
    // Loads, stores, FP, FENCE and SYSTEM only advance the PC
    default: begin
      bad = 1'b1;
    end
  endcase
  r.pc        = model_pc;
  r.next_pc   = next;
  r.rd        = inst[11:7];
  r.data      = value;
  r.writes_rd = write;
  r.illegal   = bad;
  if (write && inst[11:7] != 5'd0) begin
    model_regs[inst[11:7]] = value;
  end
  model_pc = next;
  return r;
endfunction

`endif

// ==== bench/rv_core_tb.sv ====
// RV32I core testbench
// Random instruction streams per test, checked against the reference
// model on every retire
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

  localparam rv_pkg::word_t RESET_PC    = 32'h0000_1000;
  localparam int unsigned   SEED        = 32'h2d47e641;
  localparam int            DRAIN_LIMIT = 20;
  // Instruction classes for the generator
  localparam int KIND_ARITH = 0;
  localparam int KIND_UPPER = 1;
  localparam int KIND_FLOW  = 2;
  localparam int KIND_BAD   = 3;

  logic            clock;
  logic            reset;
  logic            inst_valid;
  rv_pkg::word_t   inst;
  logic            retire_valid;
  rv_pkg::retire_t retire;

  rv_pkg::retire_t expected_q [$];
  int              check_count;
  int              error_count;
  int              errors_before;
  int              issued;

  `include "rv_ref_model.svh"

  rv_core_top #(
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clock        (clock),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #10 clock = ~clock;
    end
  end

  function automatic rv_pkg::word_t random_inst(input int kind);
    rv_pkg::word_t w;
    int            sel;
    int            pick;
    w    = $urandom;
    sel  = $urandom % 6;
    pick = $urandom % 6;
    // Registers x0 to x7 only, so results feed later instructions
    w[11:10] = 2'b00;
    w[19:18] = 2'b00;
    w[24:23] = 2'b00;
    case (kind)
      KIND_ARITH: begin
        w[6:0]   = sel[0] ? rv_pkg::OPCODE_OP : rv_pkg::OPCODE_OP_IMM;
        w[31:25] = (sel[0] || w[14:12] == 3'd1 || w[14:12] == 3'd5) ? 7'h00 : w[31:25];
        // Alternate encoding only where one exists
        if (w[14:12] == 3'd5 || (sel[0] && w[14:12] == 3'd0)) begin
          w[30] = sel[1];
        end
      end
      KIND_UPPER: w[6:0] = sel[0] ? rv_pkg::OPCODE_LUI : rv_pkg::OPCODE_AUIPC;
      KIND_FLOW: begin
        w[6:0]   = (sel == 0) ? rv_pkg::OPCODE_JAL :
                   (sel == 1) ? rv_pkg::OPCODE_JALR : rv_pkg::OPCODE_BRANCH;
        // Branch funct3 out of 0, 1, 4, 5, 6, 7
        w[14:12] = (sel == 1) ? 3'd0 : (pick < 2) ? pick[2:0] : pick[2:0] + 3'd2;
      end
      default: begin
        case (sel)
          0:       w[6:0] = rv_pkg::OPCODE_LOAD;
          1:       w[6:0] = rv_pkg::OPCODE_LOAD_FP;
          2:       w[6:0] = rv_pkg::OPCODE_STORE;
          3:       w[6:0] = rv_pkg::OPCODE_STORE_FP;
          4:       w[6:0] = 7'b0001111;
          default: w[6:0] = 7'b1110011;
        endcase
        // slli or a right shift with a stray funct7 bit
        if (pick < 2) begin
          w[6:0]   = rv_pkg::OPCODE_OP_IMM;
          w[14:12] = (pick == 0) ? 3'd1 : 3'd5;
          w[25]    = 1'b1;
        end
      end
    endcase
    return w;
  endfunction

  task automatic report_error(input string what);
    error_count++;
    $display("error: %s", what);
  endtask

  task automatic check_field(input string name, input rv_pkg::word_t got,
                             input rv_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch retire.%s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_retire(input rv_pkg::retire_t exp, input rv_pkg::retire_t got);
    check_field("pc", got.pc, exp.pc);
    check_field("next_pc", got.next_pc, exp.next_pc);
    check_field("rd", {27'd0, got.rd}, {27'd0, exp.rd});
    check_field("writes_rd", {31'd0, got.writes_rd}, {31'd0, exp.writes_rd});
    check_field("illegal", {31'd0, got.illegal}, {31'd0, exp.illegal});
    // Data is only defined for writing instructions
    if (exp.writes_rd) begin
      check_field("data", got.data, exp.data);
    end
  endtask

  // Retire port sampled mid-cycle, where it is stable
  always @(negedge clock) begin
    if (reset) begin
      if (retire_valid !== 1'b0) begin
        report_error("retire_valid high during reset");
      end
    end else if (retire_valid === 1'b1) begin
      if (expected_q.size() == 0) begin
        report_error("retire with no instruction outstanding");
      end else begin
        compare_retire(expected_q.pop_front(), retire);
      end
    end else if (retire_valid !== 1'b0) begin
      report_error("retire_valid is unknown");
    end
  end

  task automatic finish_run();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic issue_inst(input rv_pkg::word_t word);
    inst_valid = 1'b1;
    inst       = word;
    expected_q.push_back(step_model(word));
    issued++;
    @(posedge clock);
    #2;
  endtask

  // Junk on inst while the strobe is low
  task automatic idle_cycle();
    inst_valid = 1'b0;
    inst       = $urandom;
    @(posedge clock);
    #2;
  endtask

  task automatic end_test(input int num, input string name);
    int waited;
    waited     = 0;
    inst_valid = 1'b0;
    while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clock);
      #2;
      waited++;
    end
    if (expected_q.size() != 0) begin
      report_error($sformatf("test %0d: %0d instructions never retired", num,
                             expected_q.size()));
      finish_run();
    end else begin
      $display("test %0d %s: %0d instructions, %0d errors", num, name, issued,
               error_count - errors_before);
      issued        = 0;
      errors_before = error_count;
    end
  endtask

  initial begin : stimulus
    rv_pkg::word_t word;
    rv_pkg::word_t dep;
    int            pick;
    void'($urandom(SEED));
    reset         = 1'b1;
    // Strobe held high through reset, which must retire nothing
    inst_valid    = 1'b1;
    inst          = $urandom;
    check_count   = 0;
    error_count   = 0;
    errors_before = 0;
    issued        = 0;
    reset_model(RESET_PC);
    repeat (3) @(posedge clock);
    #2;
    reset      = 1'b0;
    inst_valid = 1'b0;

    // First retire must carry RESET_PC
    repeat (3) idle_cycle();
    issue_inst(random_inst(KIND_UPPER));
    end_test(1, "reset");

    repeat (60) issue_inst(random_inst(KIND_ARITH));
    end_test(2, "op and op_imm");

    repeat (40) issue_inst(random_inst(($urandom % 2 == 0) ? KIND_UPPER : KIND_ARITH));
    end_test(3, "lui and auipc");

    repeat (60) issue_inst(random_inst($urandom % 3));
    end_test(4, "control flow");

    // Illegal encodings and x0 writes, mixed with reads of the registers
    repeat (50) begin
      pick = $urandom % 3;
      word = random_inst((pick == 0) ? KIND_BAD : KIND_ARITH);
      if (pick == 1) begin
        word[11:7] = 5'd0;
      end
      issue_inst(word);
    end
    end_test(5, "x0 and illegal");

    // Idle gaps, then a pair where the second reads the first's rd
    repeat (30) begin
      if ($urandom % 3 == 0) begin
        repeat ($urandom % 3 + 1) idle_cycle();
      end
      word = random_inst($urandom % 3);
      issue_inst(word);
      dep        = random_inst(KIND_ARITH);
      dep[19:15] = word[11:7];
      issue_inst(dep);
    end
    end_test(6, "idle gaps and dependencies");

    finish_run();
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
src/rv_pkg.sv
src/immediate_generator.sv
src/instruction_decoder.sv
src/integer_execute.sv
src/register_file.sv
src/result_commit.sv
src/rv_core_top.sv
bench/rv_core_tb.sv

// ==== Makefile ====
# Verilator simulation of the RV32I core testbench

TOP := rv_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
